//--- flist.f
hdl/ex_pkg.sv
hdl/operand_forward.sv
hdl/int_alu.sv
hdl/iter_multiplier.sv
hdl/ex_result_reg.sv
hdl/execute_stage.sv
bench/execute_stage_sva.sv
bench/execute_stage_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = execute_stage_tb
FLIST     = flist.f
MDIR      = obj_dir
BIN       = $(MDIR)/V$(TOP)
SRCS      = $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(MDIR)

//--- bench/execute_stage_tb.sv
module execute_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ex_pkg::*;

  localparam int PERIOD      = 4;
  localparam int N_TESTS     = 5;
  localparam int TEST_CYCLES = 200;

  logic    bus;
  logic    arst_n;
  id_ex_t  id_ex;
  wb_fwd_t wb_fwd;
  logic    mem_hold;
  ex_mem_t ex_mem;
  logic    stall;

  // Bench's own record of what EX/MEM should hold
  ex_mem_t model_exm;
  integer  seed;

  execute_stage #(.STEP_BITS(2)) u_dut (
    .bus      (bus),
    .arst_n   (arst_n),
    .id_ex    (id_ex),
    .wb_fwd   (wb_fwd),
    .mem_hold (mem_hold),
    .ex_mem   (ex_mem),
    .stall    (stall)
  );

  initial begin
    bus = 1'b0;
    forever #(PERIOD / 2) bus = ~bus;
  end

  initial begin
    #(N_TESTS * TEST_CYCLES * PERIOD);
    give_up($sformatf("Watchdog expired after %0d cycles, the DUT stopped making progress",
                      N_TESTS * TEST_CYCLES));
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic xlen_t alu_ref(input alu_op_t op, input xlen_t a, input xlen_t b);
    logic [4:0] s;
    xlen_t      r;
    s = b[4:0];
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a + ~b + 32'd1;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_SLL:  r = a << s;
      ALU_SRL:  r = a >> s;
      // Fill vacated top bits with the sign
      ALU_SRA:  r = (a >> s) | ({XLEN{a[31]}} & ~({XLEN{1'b1}} >> s));
      // Differing signs decide on their own
      ALU_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      ALU_SLTU: r = {31'd0, a < b};
      default:  r = '0;
    endcase
    return r;
  endfunction

  // Youngest producer first and x0 never bypassed
  function automatic xlen_t fwd_ref(input reg_addr_t r, input xlen_t rf);
    if (r == 5'd0) return rf;
    if (model_exm.valid && model_exm.regwrite && model_exm.rd == r) return model_exm.result;
    if (wb_fwd.regwrite && wb_fwd.rd == r) return wb_fwd.value;
    return rf;
  endfunction

  function automatic id_ex_t alu_ins(input alu_op_t op, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                     input xlen_t v1, input xlen_t v2);
    id_ex_t ins;
    ins = '0;
    ins.valid    = 1'b1;
    ins.op       = op;
    ins.regwrite = 1'b1;
    ins.rd       = rd;
    ins.rs1      = rs1;
    ins.rs2      = rs2;
    ins.rs1_val  = v1;
    ins.rs2_val  = v2;
    return ins;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking and driving
  ////////////////////////////////////////////////////////////

  task automatic give_up(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted at first error");
  endtask

  task automatic check_eq(input string name, input xlen_t want, input xlen_t got);
    assert (got === want) else begin
      give_up($sformatf("ERROR %s: expected %h, actual %h", name, want, got));
    end
  endtask

  task automatic check_exm(input string name, input ex_mem_t want);
    check_eq({name, " ctrl"}, {23'd0, want.valid, want.regwrite, want.memread, want.memwrite,
             want.rd}, {23'd0, ex_mem.valid, ex_mem.regwrite, ex_mem.memread,
             ex_mem.memwrite, ex_mem.rd});
    check_eq({name, " result"}, want.result, ex_mem.result);
    check_eq({name, " store_data"}, want.store_data, ex_mem.store_data);
  endtask

  // Called on a falling edge
  // Hold spans hold_len cycles from cycle hold_at
  task automatic issue(input id_ex_t ins, input int hold_at, input int hold_len,
                       input string name);
    xlen_t   a;
    xlen_t   b;
    xlen_t   sd;
    ex_mem_t want;
    ex_mem_t snap;
    int      cyc;
    bit      done;
    a  = fwd_ref(ins.rs1, ins.rs1_val);
    sd = fwd_ref(ins.rs2, ins.rs2_val);
    b  = ins.use_imm ? ins.imm : sd;
    want.valid      = 1'b1;
    want.regwrite   = ins.regwrite;
    want.memread    = ins.memread;
    want.memwrite   = ins.memwrite;
    want.rd         = ins.rd;
    want.result     = ins.is_mul ? a * b : alu_ref(ins.op, a, b);
    want.store_data = sd;
    id_ex = ins;
    snap  = ex_mem;
    cyc   = 0;
    done  = 1'b0;
    while (!done) begin
      if (hold_len > 0 && cyc == hold_at) begin
        mem_hold = 1'b1;
        snap     = ex_mem;
      end
      if (hold_len > 0 && cyc == hold_at + hold_len) begin
        mem_hold = 1'b0;
      end
      // Stall settles well before the rising edge
      #1;
      if (ins.is_mul && cyc == 0) begin
        assert (stall) else give_up({name, ": MUL was presented but stall stayed low"});
      end
      // ALU flows one per cycle unless memory holds
      if (!ins.is_mul && !mem_hold) begin
        assert (!stall) else give_up({name, ": stall went high for an ALU instruction"});
      end
      if (!stall) begin
        done = 1'b1;
      end else begin
        @(negedge bus);
        cyc++;
        if (mem_hold) begin
          assert (ex_mem === snap) else give_up({name, ": EX/MEM changed during mem_hold"});
        end else if (ins.is_mul) begin
          assert (ex_mem.valid === 1'b0 && ex_mem.regwrite === 1'b0)
            else give_up({name, ": no bubble in EX/MEM while the MUL was running"});
        end
      end
    end
    @(posedge bus);
    @(negedge bus);
    check_exm(name, want);
    model_exm   = want;
    id_ex.valid = 1'b0;
  endtask

  task automatic idle(input int n);
    id_ex.valid = 1'b0;
    repeat (n) @(negedge bus);
    model_exm.valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_alu();
    xlen_t edge_a [4];
    xlen_t edge_b [4];
    xlen_t va;
    xlen_t vb;
    edge_a = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    edge_b = '{32'h0000_0000, 32'h0000_0001, 32'h0000_001f, 32'hffff_ffff};
    check_eq("reset ctrl", 32'd0, {28'd0, ex_mem.valid, ex_mem.regwrite, ex_mem.memread,
             ex_mem.memwrite});
    for (int k = 0; k < 10; k++) begin
      for (int j = 0; j < 8; j++) begin
        // Edge pairs first and random ones after
        if (j < 4) begin
          va = edge_a[j];
          vb = edge_b[j];
        end else begin
          va = $random(seed);
          vb = $random(seed);
        end
        issue(alu_ins(alu_op_t'(k), 5'd3, 5'd1, 5'd2, va, vb), 0, 0,
              $sformatf("alu op %0d pair %0d", k, j));
      end
    end
  endtask

  task automatic test_forwarding();
    id_ex_t ins;
    wb_fwd = '{regwrite: 1'b1, rd: 5'd5, value: 32'h0bad_0bad};
    issue(alu_ins(ALU_ADD, 5'd5, 5'd1, 5'd2, 32'd10, 32'd20), 0, 0, "fwd producer");
    // Both paths match x5
    issue(alu_ins(ALU_ADD, 5'd6, 5'd5, 5'd5, 32'hdead, 32'hdead), 0, 0, "fwd ex over wb");
    wb_fwd = '{regwrite: 1'b1, rd: 5'd7, value: 32'h0000_0100};
    issue(alu_ins(ALU_SUB, 5'd8, 5'd7, 5'd6, 32'h7777, 32'h6666), 0, 0, "fwd wb only");
    wb_fwd = '{regwrite: 1'b1, rd: 5'd0, value: 32'h0000_1234};
    issue(alu_ins(ALU_ADD, 5'd0, 5'd1, 5'd2, 32'd3, 32'd4), 0, 0, "fwd x0 producer");
    issue(alu_ins(ALU_OR, 5'd9, 5'd0, 5'd0, 32'd0, 32'd0), 0, 0, "fwd x0 blocked");
    ins = alu_ins(ALU_ADD, 5'd10, 5'd9, 5'd9, 32'h5a5a, 32'h5a5a);
    ins.use_imm = 1'b1;
    ins.imm     = 32'h0000_0055;
    issue(ins, 0, 0, "fwd use_imm");
    wb_fwd = '0;
  endtask

  task automatic test_store();
    id_ex_t ins;
    issue(alu_ins(ALU_ADD, 5'd11, 5'd1, 5'd2, 32'd100, 32'd23), 0, 0, "store producer");
    // Store data is the bypassed x11
    ins = alu_ins(ALU_ADD, 5'd0, 5'd2, 5'd11, 32'h0000_1000, 32'd0);
    ins.regwrite = 1'b0;
    ins.memwrite = 1'b1;
    ins.use_imm  = 1'b1;
    ins.imm      = 32'd8;
    issue(ins, 0, 0, "store data");
    wb_fwd = '{regwrite: 1'b1, rd: 5'd11, value: 32'd123};
    ins = alu_ins(ALU_ADD, 5'd12, 5'd11, 5'd3, 32'd0, 32'd0);
    ins.memread = 1'b1;
    ins.use_imm = 1'b1;
    ins.imm     = 32'd4;
    issue(ins, 0, 0, "load address");
    wb_fwd = '0;
  endtask

  task automatic test_mul();
    xlen_t  ma [4];
    xlen_t  mb [4];
    id_ex_t ins;
    ma = '{32'd7, 32'hffff_fffd, 32'h8000_0001, 32'd0};
    mb = '{32'd6, 32'd5, 32'hffff_ffff, 32'd0};
    ma[3] = $random(seed);
    mb[3] = $random(seed);
    for (int j = 0; j < 4; j++) begin
      ins = alu_ins(ALU_ADD, 5'd13, 5'd1, 5'd2, ma[j], mb[j]);
      ins.is_mul = 1'b1;
      issue(ins, 0, 0, $sformatf("mul %0d", j));
      // Consumer of the product right behind it
      issue(alu_ins(ALU_XOR, 5'd14, 5'd13, 5'd1, 32'd0, 32'h00ff_00ff), 0, 0,
            $sformatf("alu after mul %0d", j));
    end
  endtask

  task automatic test_hold();
    id_ex_t ins;
    issue(alu_ins(ALU_ADD, 5'd15, 5'd1, 5'd2, 32'd1, 32'd2), 0, 0, "hold first");
    issue(alu_ins(ALU_SLL, 5'd16, 5'd15, 5'd2, 32'd0, 32'd4), 0, 3, "hold alu");
    issue(alu_ins(ALU_SUB, 5'd17, 5'd16, 5'd2, 32'd0, 32'd5), 0, 0, "hold after");
    // Hold long enough to park the MUL in DONE
    wb_fwd = '{regwrite: 1'b1, rd: 5'd16, value: 32'd12};
    ins = alu_ins(ALU_ADD, 5'd18, 5'd17, 5'd16, 32'd0, 32'd0);
    ins.is_mul = 1'b1;
    issue(ins, 4, 20, "hold mul done");
    wb_fwd = '0;
    issue(alu_ins(ALU_OR, 5'd19, 5'd18, 5'd0, 32'd0, 32'd0), 0, 0, "hold mul next");
    idle(2);
    check_eq("hold no duplicate", 32'd0, {31'd0, ex_mem.valid});
  endtask

  initial begin
    seed      = 32'h4252c042;
    // Valid instruction waiting in reset must not reach EX/MEM
    id_ex     = alu_ins(ALU_ADD, 5'd1, 5'd2, 5'd3, 32'd1, 32'd2);
    wb_fwd    = '0;
    mem_hold  = 1'b0;
    arst_n    = 1'b0;
    model_exm = '0;
    repeat (2) @(negedge bus);
    arst_n = 1'b1;
    test_reset_alu();
    test_forwarding();
    test_store();
    test_mul();
    test_hold();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- bench/execute_stage_sva.sv
module execute_stage_sva (
  input logic            bus,
  input logic            arst_n,
  input logic            mem_hold,
  input ex_pkg::ex_mem_t ex_mem,
  input logic            stall
);

  timeunit 1ns;
  timeprecision 1ps;

  // EX/MEM frozen across a held edge
  hold_freezes: assert property (
    @(posedge bus) disable iff (!arst_n) mem_hold |=> $stable(ex_mem)
  ) else $error("EX/MEM changed after an edge with mem_hold high");

  // Bubbles carry no side effects
  bubble_clean: assert property (
    @(posedge bus) disable iff (!arst_n)
    !ex_mem.valid |-> !(ex_mem.regwrite || ex_mem.memread || ex_mem.memwrite)
  ) else $error("EX/MEM bubble carries a write or memory flag");

  // Memory hold always stalls upstream
  hold_stalls: assert property (
    @(posedge bus) disable iff (!arst_n) mem_hold |-> stall
  ) else $error("stall low while mem_hold is high");

endmodule

bind execute_stage execute_stage_sva u_sva (
  .bus      (bus),
  .arst_n   (arst_n),
  .mem_hold (mem_hold),
  .ex_mem   (ex_mem),
  .stall    (stall)
);

//--- hdl/execute_stage.sv
module execute_stage #(
  parameter int STEP_BITS = 2
) (
  input  logic            bus,
  input  logic            arst_n,
  input  ex_pkg::id_ex_t  id_ex,
  input  ex_pkg::wb_fwd_t wb_fwd,
  input  logic            mem_hold,
  output ex_pkg::ex_mem_t ex_mem,
  output logic            stall
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  // Selected operands
  xlen_t op_a;
  xlen_t op_b;
  xlen_t store_data;

  // Unit results
  xlen_t alu_res;
  xlen_t mul_res;
  logic  mul_ready;
  logic  take;

  // Registered EX/MEM loops back for bypass
  operand_forward u_fwd (
    .id_ex      (id_ex),
    .ex_mem     (ex_mem),
    .wb_fwd     (wb_fwd),
    .op_a       (op_a),
    .op_b       (op_b),
    .store_data (store_data)
  );

  int_alu u_alu (
    .op_a    (op_a),
    .op_b    (op_b),
    .op      (id_ex.op),
    .alu_res (alu_res)
  );

  iter_multiplier #(.STEP_BITS(STEP_BITS)) u_mul (
    .bus         (bus),
    .arst_n      (arst_n),
    .start_valid (id_ex.valid && id_ex.is_mul),
    .op_a        (op_a),
    .op_b        (op_b),
    .take        (take),
    .mul_res     (mul_res),
    .mul_ready   (mul_ready)
  );

  ex_result_reg u_res (
    .bus        (bus),
    .arst_n     (arst_n),
    .id_ex      (id_ex),
    .alu_res    (alu_res),
    .mul_res    (mul_res),
    .mul_ready  (mul_ready),
    .store_data (store_data),
    .mem_hold   (mem_hold),
    .ex_mem     (ex_mem),
    .stall      (stall),
    .take       (take)
  );

endmodule

//--- hdl/ex_result_reg.sv
module ex_result_reg (
  input  logic            bus,
  input  logic            arst_n,
  input  ex_pkg::id_ex_t  id_ex,
  input  ex_pkg::xlen_t   alu_res,
  input  ex_pkg::xlen_t   mul_res,
  input  logic            mul_ready,
  input  ex_pkg::xlen_t   store_data,
  input  logic            mem_hold,
  output ex_pkg::ex_mem_t ex_mem,
  output logic            stall,
  output logic            take
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////
  // Stall and capture
  ////////////////////////////////////////////////////////////

  logic  mul_valid;
  logic  mul_wait;
  xlen_t result;

  // Control half of EX/MEM
  logic valid_q;
  logic regwrite_q;
  logic memread_q;
  logic memwrite_q;

  // Payload half of EX/MEM
  reg_addr_t rd_q;
  xlen_t     result_q;
  xlen_t     store_q;

  assign mul_valid = id_ex.valid && id_ex.is_mul;

  // Product not there yet
  assign mul_wait = mul_valid && !mul_ready;

  assign stall = mem_hold || mul_wait;

  // Product leaves the multiplier this edge
  assign take = mul_valid && mul_ready && !mem_hold;

  assign result = id_ex.is_mul ? mul_res : alu_res;

  ////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      valid_q    <= 1'b0;
      regwrite_q <= 1'b0;
      memread_q  <= 1'b0;
      memwrite_q <= 1'b0;
    end else if (!mem_hold) begin
      // Bubble while MUL runs, else load
      valid_q    <= id_ex.valid && !mul_wait;
      regwrite_q <= id_ex.valid && !mul_wait && id_ex.regwrite;
      memread_q  <= id_ex.valid && !mul_wait && id_ex.memread;
      memwrite_q <= id_ex.valid && !mul_wait && id_ex.memwrite;
    end
  end

  always_ff @(posedge bus) begin
    if (!stall) begin
      rd_q     <= id_ex.rd;
      result_q <= result;
      store_q  <= store_data;
    end
  end

  assign ex_mem = '{
    valid:      valid_q,
    regwrite:   regwrite_q,
    memread:    memread_q,
    memwrite:   memwrite_q,
    rd:         rd_q,
    result:     result_q,
    store_data: store_q
  };

endmodule

//--- hdl/iter_multiplier.sv
module iter_multiplier #(
  parameter int STEP_BITS = 2
) (
  input  logic          bus,
  input  logic          arst_n,
  input  logic          start_valid,
  input  ex_pkg::xlen_t op_a,
  input  ex_pkg::xlen_t op_b,
  input  logic          take,
  output ex_pkg::xlen_t mul_res,
  output logic          mul_ready
);

  import ex_pkg::*;

  // Cycles spent in RUN
  localparam int STEPS = XLEN / STEP_BITS;
  localparam int CNT_W = $clog2(STEPS);

  mul_state_t       state_q;
  logic [CNT_W-1:0] cnt_q;

  // Accumulator and shifting operands
  xlen_t acc_q;
  xlen_t mcand_q;
  xlen_t mplier_q;
  xlen_t part_sum;

  ////////////////////////////////////////////////////////////
  // Partial products for one step
  ////////////////////////////////////////////////////////////

  always_comb begin
    part_sum = '0;
    // Low product only, so signed and unsigned agree
    for (int i = 0; i < STEP_BITS; i++) begin
      if (mplier_q[i]) begin
        part_sum = part_sum + (mcand_q << i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (start_valid) begin
            state_q <= RUN;
          end
        end
        RUN: begin
          cnt_q <= cnt_q + CNT_W'(1);
          // Last step retires the top bits
          if (cnt_q == CNT_W'(STEPS - 1)) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // Hold product until captured
          if (take) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge bus) begin
    if ((state_q == IDLE) && start_valid) begin
      acc_q    <= '0;
      mcand_q  <= op_a;
      mplier_q <= op_b;
    end else if (state_q == RUN) begin
      acc_q    <= acc_q + part_sum;
      mcand_q  <= mcand_q << STEP_BITS;
      mplier_q <= mplier_q >> STEP_BITS;
    end
  end

  assign mul_res   = acc_q;
  assign mul_ready = (state_q == DONE);

endmodule

//--- hdl/int_alu.sv
module int_alu (
  input  ex_pkg::xlen_t   op_a,
  input  ex_pkg::xlen_t   op_b,
  input  ex_pkg::alu_op_t op,
  output ex_pkg::xlen_t   alu_res
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////
  // Shared terms
  ////////////////////////////////////////////////////////////

  // Shift amount, RV32 uses five bits
  logic [4:0] shamt;

  // Comparison flags
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  ////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op)
      // Arithmetic
      ALU_ADD: begin
        alu_res = op_a + op_b;
      end
      ALU_SUB: begin
        alu_res = op_a - op_b;
      end
      // Bitwise logic
      ALU_AND: begin
        alu_res = op_a & op_b;
      end
      ALU_OR: begin
        alu_res = op_a | op_b;
      end
      ALU_XOR: begin
        alu_res = op_a ^ op_b;
      end
      // Logical shifts
      ALU_SLL: begin
        alu_res = op_a << shamt;
      end
      ALU_SRL: begin
        alu_res = op_a >> shamt;
      end
      // Arithmetic shift keeps the sign
      ALU_SRA: begin
        alu_res = xlen_t'($signed(op_a) >>> shamt);
      end
      // Set less than, result is 0 or 1
      ALU_SLT: begin
        alu_res = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        alu_res = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      // Unused codes
      default: begin
        alu_res = '0;
      end
    endcase
  end

endmodule

//--- hdl/operand_forward.sv
module operand_forward (
  input  ex_pkg::id_ex_t  id_ex,
  input  ex_pkg::ex_mem_t ex_mem,
  input  ex_pkg::wb_fwd_t wb_fwd,
  output ex_pkg::xlen_t   op_a,
  output ex_pkg::xlen_t   op_b,
  output ex_pkg::xlen_t   store_data
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////
  // Bypass selection
  ////////////////////////////////////////////////////////////

  // Forwarded register values before the immediate mux
  xlen_t rs1_fwd;
  xlen_t rs2_fwd;

  // One source register against both bypass paths
  function automatic xlen_t pick_src(
    input reg_addr_t src,
    input xlen_t     rf_val,
    input ex_mem_t   exm,
    input wb_fwd_t   wb
  );
    xlen_t val;
    // Default is the register file read
    val = rf_val;
    // x0 is hardwired, never bypassed
    if (src != '0) begin
      // Youngest producer wins
      if (exm.valid && exm.regwrite && (exm.rd == src)) begin
        val = exm.result;
      end else if (wb.regwrite && (wb.rd == src)) begin
        val = wb.value;
      end
    end
    return val;
  endfunction

  always_comb begin
    rs1_fwd = pick_src(id_ex.rs1, id_ex.rs1_val, ex_mem, wb_fwd);
    rs2_fwd = pick_src(id_ex.rs2, id_ex.rs2_val, ex_mem, wb_fwd);
  end

  ////////////////////////////////////////////////////////////
  // Operand outputs
  ////////////////////////////////////////////////////////////

  // Operand a always from rs1
  assign op_a = rs1_fwd;

  // I-type replaces rs2 with the immediate
  assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  // Stores still need the real rs2 value
  assign store_data = rs2_fwd;

endmodule

//--- hdl/ex_pkg.sv
package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data path width, RV32 only
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;

  ////////////////////////////////////////////////////////////
  // ALU operation codes
  ////////////////////////////////////////////////////////////

  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;

  ////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////

  // Decoded instruction in ID/EX
  typedef struct packed {
    logic      valid;
    alu_op_t   op;
    // MUL, op is don't care
    logic      is_mul;
    logic      use_imm;
    logic      regwrite;
    logic      memread;
    logic      memwrite;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    xlen_t     imm;
  } id_ex_t;

  // EX/MEM register contents
  typedef struct packed {
    logic      valid;
    logic      regwrite;
    logic      memread;
    logic      memwrite;
    reg_addr_t rd;
    xlen_t     result;
    xlen_t     store_data;
  } ex_mem_t;

  // Write-back bypass from MEM/WB
  typedef struct packed {
    logic      regwrite;
    reg_addr_t rd;
    xlen_t     value;
  } wb_fwd_t;

  // Multiplier sequencing
  typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_t;

endpackage
